// File: include/core_defines.svh
// ------------------------------------------------------------------------
// Core configuration macros
// Word, field and address widths and the depths of both stacks
// ------------------------------------------------------------------------

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and instruction fields
`define CORE_WORD_W       16
`define CORE_OPC_W        5
`define CORE_OPR_W        11

// Address spaces
`define CORE_IADDR_W      8
`define CORE_DADDR_W      6
`define CORE_IOADDR_W     4

// Stack depths
`define CORE_DSTACK_DEPTH 8
`define CORE_RSTACK_DEPTH 8

`endif

// File: hdl/isa_pkg.sv
// ------------------------------------------------------------------------
// Instruction set types
// Opcode encoding and the layout of the 16-bit instruction word
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

package isa_pkg;

	// Encoding follows list order, nop is zero
	typedef enum logic [`CORE_OPC_W-1:0] {
		op_nop, op_ldc, op_lod, op_set, op_psh,
		op_add, op_sub, op_and, op_orr, op_xor,
		op_inv, op_shl, op_shr, op_les, op_equ,
		op_inn, op_out,
		op_jmp, op_jiz, op_cal, op_ret
	} opcode_t;

	typedef logic [`CORE_OPR_W-1:0]   operand_t;
	typedef logic [`CORE_IADDR_W-1:0] iaddr_t;

	// Opcode in the upper bits, operand below
	typedef struct packed {
		opcode_t  opcode;
		operand_t operand;
	} instr_t;

endpackage

`default_nettype wire

// File: hdl/datapath_pkg.sv
// ------------------------------------------------------------------------
// Datapath types
// Data word, address types and the ALU and accumulator source selects
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

package datapath_pkg;

	typedef logic [`CORE_WORD_W-1:0]   word_t;
	typedef logic [`CORE_DADDR_W-1:0]  daddr_t;
	typedef logic [`CORE_IOADDR_W-1:0] ioaddr_t;

	typedef enum logic [3:0] {
		alu_pass, alu_add, alu_sub, alu_and, alu_orr, alu_xor,
		alu_inv, alu_shl, alu_shr, alu_les, alu_equ
	} alu_op_t;

	// Accumulator load source
	typedef enum logic [1:0] {
		src_alu, src_const, src_mem, src_io
	} src_t;

endpackage

`default_nettype wire

// File: hdl/lifo.sv
// ------------------------------------------------------------------------
// Last-in-first-out store
// Register array addressed by a single pointer, top is always visible
// ------------------------------------------------------------------------

`default_nettype none

module lifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             push,
	input  wire logic             pop,
	input  wire logic [WIDTH-1:0] din,
	output logic      [WIDTH-1:0] top
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [0:DEPTH-1];
	// Points at the next free entry
	logic [PTR_W-1:0] ptr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Entry just below the pointer
	assign top = mem[ptr - 1'b1];

endmodule

`default_nettype wire

// File: hdl/alu.sv
// ------------------------------------------------------------------------
// Integer ALU
// Arithmetic, logic, compare and shift on stack top and accumulator
// ------------------------------------------------------------------------

`default_nettype none

module alu import datapath_pkg::*; (
	input  wire alu_op_t op,
	input  wire word_t   a,
	input  wire word_t   b,
	output word_t        y
);

	// a is the stack top, b the accumulator
	always_comb begin
		case (op)
			alu_pass: y = b;

			// Wraps modulo the word width
			alu_add: y = a + b;
			alu_sub: y = a - b;

			// Bitwise
			alu_and: y = a & b;
			alu_orr: y = a | b;
			alu_xor: y = a ^ b;
			alu_inv: y = ~b;

			// Shift amount is the low 4 bits of acc, zero fill
			alu_shl: y = a << b[3:0];
			alu_shr: y = a >> b[3:0];

			// Compares return 0 or 1
			alu_les: y = word_t'($signed(a) < $signed(b));
			alu_equ: y = word_t'(a == b);

			default: y = b;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
// ------------------------------------------------------------------------
// Data memory
// Synchronous write, combinational read
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module data_ram import datapath_pkg::*; (
	input  wire logic   clk,
	input  wire logic   wr,
	input  wire daddr_t addr,
	input  wire word_t  wdata,
	output word_t       rdata
);

	word_t mem [0:(2**`CORE_DADDR_W)-1];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: hdl/io_port.sv
// ------------------------------------------------------------------------
// I/O port
// Direct input request, registered output strobe with address and data
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module io_port import isa_pkg::*, datapath_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     in_req,
	input  wire logic     out_req,
	input  wire operand_t operand,
	input  wire word_t    acc,
	output logic          req_in,
	output ioaddr_t       addr_in,
	output logic          out_en,
	output ioaddr_t       addr_out,
	output word_t         io_out
);

	// Input side is combinational in the inn cycle
	assign req_in  = in_req;
	assign addr_in = operand[`CORE_IOADDR_W-1:0];

	// One-cycle strobe after out
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en <= 1'b0;
		end else begin
			out_en <= out_req;
		end
	end

	// Held until the next out
	always_ff @(posedge clk) begin
		if (out_req) begin
			addr_out <= operand[`CORE_IOADDR_W-1:0];
			io_out   <= acc;
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_dec.sv
// ------------------------------------------------------------------------
// Instruction decoder
// Maps each opcode to the datapath, memory and I/O controls
// ------------------------------------------------------------------------

`default_nettype none

module instr_dec import isa_pkg::*, datapath_pkg::*; (
	input  wire opcode_t opcode,
	output alu_op_t      alu_op,
	output src_t         src_sel,
	output logic         acc_en,
	output logic         dpush,
	output logic         dpop,
	output logic         mem_wr,
	output logic         in_req,
	output logic         out_req
);

	// Binary operations take the stack top and pop it
	always_comb begin
		alu_op  = alu_pass;
		src_sel = src_alu;
		acc_en  = 1'b0;
		dpush   = 1'b0;
		dpop    = 1'b0;
		mem_wr  = 1'b0;
		in_req  = 1'b0;
		out_req = 1'b0;

		case (opcode)
			// Loads and stores
			op_ldc: begin
				src_sel = src_const;
				acc_en  = 1'b1;
			end
			op_lod: begin
				src_sel = src_mem;
				acc_en  = 1'b1;
			end
			op_set: mem_wr = 1'b1;
			op_psh: dpush  = 1'b1;

			// Two-operand ALU
			op_add, op_sub, op_and, op_orr, op_xor,
			op_shl, op_shr, op_les, op_equ: begin
				acc_en = 1'b1;
				dpop   = 1'b1;
				case (opcode)
					op_add:  alu_op = alu_add;
					op_sub:  alu_op = alu_sub;
					op_and:  alu_op = alu_and;
					op_orr:  alu_op = alu_orr;
					op_xor:  alu_op = alu_xor;
					op_shl:  alu_op = alu_shl;
					op_shr:  alu_op = alu_shr;
					op_les:  alu_op = alu_les;
					default: alu_op = alu_equ;
				endcase
			end

			// Single operand, stack untouched
			op_inv: begin
				alu_op = alu_inv;
				acc_en = 1'b1;
			end

			// I/O
			op_inn: begin
				src_sel = src_io;
				acc_en  = 1'b1;
				in_req  = 1'b1;
			end
			op_out: out_req = 1'b1;

			// nop and jumps leave the datapath alone
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// ------------------------------------------------------------------------
// Execution unit
// Accumulator, its source select and the data stack of left operands
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module exec_unit import isa_pkg::*, datapath_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire alu_op_t  alu_op,
	input  wire src_t     src_sel,
	input  wire logic     acc_en,
	input  wire logic     dpush,
	input  wire logic     dpop,
	input  wire operand_t operand,
	input  wire word_t    mem_rdata,
	input  wire word_t    io_in,
	output word_t         acc
);

	word_t stack_top;
	word_t alu_y;
	word_t acc_next;

	alu alu_inst (
		.op(alu_op),
		.a (stack_top),
		.b (acc),
		.y (alu_y)
	);

	// Data stack only ever receives the accumulator
	lifo #(
		.WIDTH($bits(word_t)),
		.DEPTH(`CORE_DSTACK_DEPTH)
	) dstack_inst (
		.clk (clk),
		.rst (rst),
		.push(dpush),
		.pop (dpop),
		.din (acc),
		.top (stack_top)
	);

	always_comb begin
		case (src_sel)
			src_const: acc_next = word_t'(operand);
			src_mem:   acc_next = mem_rdata;
			src_io:    acc_next = io_in;
			default:   acc_next = alu_y;
		endcase
	end

	// io_in is taken at the closing edge of inn
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (acc_en) begin
			acc <= acc_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_fetch.sv
// ------------------------------------------------------------------------
// Instruction fetch
// Program counter, next-address select and the return-address stack
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module instr_fetch import isa_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire instr_t instr,
	input  wire logic   acc_lsb,
	output iaddr_t      instr_addr,
	output opcode_t     opcode,
	output operand_t    operand
);

	iaddr_t pc;
	iaddr_t ret_top;
	logic   fetch_valid;
	logic   take_jump;
	logic   is_call;
	logic   is_ret;

	// ------------------------------------------------------------------------
	// Instruction split
	// ------------------------------------------------------------------------

	// ROM word is stale in the first cycle out of reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b1;
		end
	end

	assign opcode  = fetch_valid ? instr.opcode : op_nop;
	assign operand = fetch_valid ? instr.operand : '0;

	// ------------------------------------------------------------------------
	// Next address
	// ------------------------------------------------------------------------

	assign is_call   = (opcode == op_cal);
	assign is_ret    = (opcode == op_ret);
	// jiz tests the result left by the previous instruction
	assign take_jump = (opcode == op_jmp) || is_call ||
		((opcode == op_jiz) && !acc_lsb);

	// Target goes straight to the ROM, so no bubble
	always_comb begin
		if (is_ret) begin
			instr_addr = ret_top;
		end else if (take_jump) begin
			instr_addr = operand[`CORE_IADDR_W-1:0];
		end else begin
			instr_addr = pc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= instr_addr + 1'b1;
		end
	end

	// pc already holds the address after the call
	lifo #(
		.WIDTH(`CORE_IADDR_W),
		.DEPTH(`CORE_RSTACK_DEPTH)
	) rstack_inst (
		.clk (clk),
		.rst (rst),
		.push(is_call),
		.pop (is_ret),
		.din (pc),
		.top (ret_top)
	);

endmodule

`default_nettype wire

// File: hdl/core_top.sv
// ------------------------------------------------------------------------
// Stack and accumulator processor core
// One instruction per cycle, external ROM, internal data memory
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module core_top import isa_pkg::*, datapath_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire instr_t instr,
	output iaddr_t      instr_addr,
	input  wire word_t  io_in,
	output logic        req_in,
	output ioaddr_t     addr_in,
	output logic        out_en,
	output ioaddr_t     addr_out,
	output word_t       io_out
);

	opcode_t  opcode;
	operand_t operand;
	alu_op_t  alu_op;
	src_t     src_sel;
	logic     acc_en;
	logic     dpush;
	logic     dpop;
	logic     mem_wr;
	logic     in_req;
	logic     out_req;
	word_t    acc;
	word_t    mem_rdata;

	// ------------------------------------------------------------------------
	// Fetch and decode
	// ------------------------------------------------------------------------

	instr_fetch instr_fetch_inst (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.acc_lsb   (acc[0]),
		.instr_addr(instr_addr),
		.opcode    (opcode),
		.operand   (operand)
	);

	instr_dec instr_dec_inst (
		.opcode (opcode),
		.alu_op (alu_op),
		.src_sel(src_sel),
		.acc_en (acc_en),
		.dpush  (dpush),
		.dpop   (dpop),
		.mem_wr (mem_wr),
		.in_req (in_req),
		.out_req(out_req)
	);

	// ------------------------------------------------------------------------
	// Execute, memory and I/O
	// ------------------------------------------------------------------------

	exec_unit exec_unit_inst (
		.clk      (clk),
		.rst      (rst),
		.alu_op   (alu_op),
		.src_sel  (src_sel),
		.acc_en   (acc_en),
		.dpush    (dpush),
		.dpop     (dpop),
		.operand  (operand),
		.mem_rdata(mem_rdata),
		.io_in    (io_in),
		.acc      (acc)
	);

	// Direct addressing from the operand field
	data_ram data_ram_inst (
		.clk  (clk),
		.wr   (mem_wr),
		.addr (operand[`CORE_DADDR_W-1:0]),
		.wdata(acc),
		.rdata(mem_rdata)
	);

	io_port io_port_inst (
		.clk     (clk),
		.rst     (rst),
		.in_req  (in_req),
		.out_req (out_req),
		.operand (operand),
		.acc     (acc),
		.req_in  (req_in),
		.addr_in (addr_in),
		.out_en  (out_en),
		.addr_out(addr_out),
		.io_out  (io_out)
	);

endmodule

`default_nettype wire

// File: bench/core_tb.sv
// ------------------------------------------------------------------------
// Testbench for the stack and accumulator core
// Synchronous ROM model, output monitor, directed program tests
// ------------------------------------------------------------------------

`default_nettype none

`include "core_defines.svh"

module core_tb import isa_pkg::*, datapath_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROM_DEPTH   = 2 ** `CORE_IADDR_W;
	localparam int DRIVE_DELAY = 2;
	localparam int RST_CYCLES  = 4;
	localparam int RUN_LIMIT   = 200;
	localparam int TAIL_CYCLES = 20;
	// Six tests of at most 225 cycles each, plus margin
	localparam int CYCLE_LIMIT = 2000;
	// Leading out runs in cycle 2, strobe in cycle 3
	localparam int FIRST_OUT_CYCLE = 3;

	logic    clk;
	logic    rst;
	instr_t  instr;
	iaddr_t  instr_addr;
	word_t   io_in;
	logic    req_in;
	ioaddr_t addr_in;
	logic    out_en;
	ioaddr_t addr_out;
	word_t   io_out;

	instr_t  rom [0:ROM_DEPTH-1];
	instr_t  fetched;
	int      fill_ptr;
	word_t   io_table [0:255];
	int      cycle_count;
	int      since_rst;
	int      first_out;

	// Captured by the monitor
	ioaddr_t got_addr [$];
	word_t   got_data [$];
	ioaddr_t in_addr [$];
	word_t   in_data [$];
	// Expected outputs of the current program
	ioaddr_t exp_addr [$];
	word_t   exp_data [$];

	string   cur_test;
	int      errors;
	int      test_errors;
	int      checks;
	int      tests_run;
	int      tests_failed;

	core_top core_top_inst (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.instr_addr(instr_addr),
		.io_in     (io_in),
		.req_in    (req_in),
		.addr_in   (addr_in),
		.out_en    (out_en),
		.addr_out  (addr_out),
		.io_out    (io_out)
	);

	// ------------------------------------------------------------------------
	// Clock, ROM, input driver, monitor, watchdog
	// ------------------------------------------------------------------------

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Address settles mid-cycle, word appears just after the next edge
	always begin
		@(negedge clk);
		fetched = rom[instr_addr];
		@(posedge clk);
		#DRIVE_DELAY;
		instr = fetched;
	end

	always begin
		@(posedge clk);
		#DRIVE_DELAY;
		io_in = io_table[cycle_count[7:0]];
	end

	// Mid-cycle sampling, all outputs stable here
	always @(negedge clk) begin
		if (rst) begin
			since_rst = 0;
		end else begin
			since_rst++;
		end
		if (out_en) begin
			got_addr.push_back(addr_out);
			got_data.push_back(io_out);
			if (first_out < 0) begin
				first_out = since_rst;
			end
		end
		// io_in held until the closing edge of inn
		if (req_in) begin
			in_addr.push_back(addr_in);
			in_data.push_back(io_in);
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles, tests did not complete", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Checks and bookkeeping
	// ------------------------------------------------------------------------

	task automatic report_error(string msg);
		$display("%s: %s", cur_test, msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h (%s)", name, got, exp, cur_test);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_ioaddr(string name, ioaddr_t got, ioaddr_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h (%s)", name, got, exp, cur_test);
			errors++;
			test_errors++;
		end
	endtask

	// Reference result of top op acc, worked in integers
	function automatic word_t alu_expect(opcode_t op, word_t a, word_t b);
		int    ia;
		int    ib;
		int    sa;
		int    sb;
		int    sh;
		int    ones;
		word_t r_and;
		word_t r_orr;
		word_t r_xor;
		ia = int'(a);
		ib = int'(b);
		sa = a[15] ? ia - 65536 : ia;
		sb = b[15] ? ib - 65536 : ib;
		sh = ib % 16;
		// Bitwise results from the count of set bits in each position
		for (int i = 0; i < 16; i++) begin
			ones = int'(a[i]) + int'(b[i]);
			r_and[i] = (ones == 2);
			r_orr[i] = (ones >= 1);
			r_xor[i] = (ones == 1);
		end
		case (op)
			op_add:  return word_t'(ia + ib);
			op_sub:  return word_t'(ia - ib);
			op_and:  return r_and;
			op_orr:  return r_orr;
			op_xor:  return r_xor;
			op_shl:  return word_t'(ia * (2 ** sh));
			op_shr:  return word_t'(ia / (2 ** sh));
			op_inv:  return word_t'(65535 - ib);
			op_les:  return (sa < sb) ? 16'd1 : 16'd0;
			op_equ:  return (ia == ib) ? 16'd1 : 16'd0;
			default: return b;
		endcase
	endfunction

	// Holds the core in reset and clears the ROM and queues
	task automatic begin_test(string name);
		@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		cur_test = name;
		test_errors = 0;
		first_out = -1;
		fill_ptr = 0;
		// Every unused word jumps to itself
		for (int a = 0; a < ROM_DEPTH; a++) begin
			rom[a] = '{opcode: op_jmp, operand: operand_t'(a)};
		end
		got_addr.delete();
		got_data.delete();
		in_addr.delete();
		in_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic place(int addr);
		fill_ptr = addr;
	endtask

	task automatic emit(opcode_t op, int opr);
		rom[fill_ptr] = '{opcode: op, operand: operand_t'(opr)};
		fill_ptr++;
	endtask

	task automatic expect_out(int addr, word_t data);
		exp_addr.push_back(ioaddr_t'(addr));
		exp_data.push_back(data);
	endtask

	// Releases reset, waits for n strobes, then idles to catch extras
	task automatic run_program(int n);
		int cycles;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		cycles = 0;
		// Queues only change at the falling edge
		while ((got_data.size() < n) && (cycles < RUN_LIMIT)) begin
			@(posedge clk);
			cycles++;
		end
		if (got_data.size() < n) begin
			report_error($sformatf("only %0d of %0d outputs arrived within %0d cycles",
				got_data.size(), n, RUN_LIMIT));
		end
		repeat (TAIL_CYCLES) @(posedge clk);
	endtask

	task automatic compare_outputs();
		int n;
		n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
		if (got_data.size() != exp_data.size()) begin
			report_error($sformatf("%0d outputs seen where %0d were expected",
				got_data.size(), exp_data.size()));
		end
		for (int i = 0; i < n; i++) begin
			check_ioaddr($sformatf("addr_out[%0d]", i), got_addr[i], exp_addr[i]);
			check_word($sformatf("io_out[%0d]", i), got_data[i], exp_data[i]);
		end
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%-10s ok", cur_test);
		end else begin
			tests_failed++;
			$display("%-10s %0d errors", cur_test, test_errors);
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------

	task automatic constant_outputs();
		int vals [0:4];
		int addrs [0:4];
		vals  = '{'h123, 'h7ff, 'h000, 'h400, 'h055};
		addrs = '{1, 15, 0, 8, 5};
		begin_test("constants");
		// Reset value of the accumulator goes out first
		emit(op_out, 2);
		expect_out(2, 16'h0000);
		for (int k = 0; k < 5; k++) begin
			emit(op_ldc, vals[k]);
			emit(op_out, addrs[k]);
			expect_out(addrs[k], word_t'(vals[k]));
		end
		run_program(exp_data.size());
		compare_outputs();
		// Stale ROM word after reset must not execute
		if (first_out != FIRST_OUT_CYCLE) begin
			report_error($sformatf("first output came in cycle %0d after reset, not %0d",
				first_out, FIRST_OUT_CYCLE));
		end
		finish_test();
	endtask

	task automatic stack_arith();
		opcode_t ops [0:9];
		word_t   a;
		word_t   b;
		ops = '{op_add, op_sub, op_and, op_orr, op_xor,
			op_shl, op_shr, op_inv, op_les, op_equ};
		begin_test("alu");
		for (int k = 0; k < 10; k++) begin
			a = word_t'($urandom & 32'h7ff);
			b = word_t'($urandom & 32'h7ff);
			// Equal operands so equ returns 1
			if (ops[k] == op_equ) begin
				b = a;
			end
			emit(op_ldc, int'(a));
			emit(op_psh, 0);
			emit(op_ldc, int'(b));
			emit(ops[k], 0);
			emit(op_out, k + 1);
			expect_out(k + 1, alu_expect(ops[k], a, b));
		end
		run_program(exp_data.size());
		compare_outputs();
		finish_test();
	endtask

	task automatic memory_roundtrip();
		int    addrs [0:3];
		int    order [0:3];
		word_t vals [0:3];
		addrs = '{3, 17, 40, 63};
		order = '{2, 0, 3, 1};
		begin_test("memory");
		for (int k = 0; k < 4; k++) begin
			vals[k] = word_t'($urandom & 32'h7ff);
			emit(op_ldc, int'(vals[k]));
			// One stored word with the upper bits set
			if (k == 2) begin
				emit(op_inv, 0);
				vals[k] = ~vals[k];
			end
			emit(op_set, addrs[k]);
		end
		for (int k = 0; k < 4; k++) begin
			emit(op_lod, addrs[order[k]]);
			emit(op_out, 8 + k);
			expect_out(8 + k, vals[order[k]]);
		end
		run_program(exp_data.size());
		compare_outputs();
		finish_test();
	endtask

	// Counter in mem[0], outputs count then count-1 until it hits zero
	task automatic countdown_loop();
		int start;
		start = 5;
		begin_test("loop");
		emit(op_ldc, start);
		emit(op_set, 0);
		emit(op_out, 7);
		emit(op_psh, 0);
		emit(op_ldc, 1);
		emit(op_sub, 0);
		emit(op_set, 0);
		emit(op_psh, 0);
		emit(op_ldc, 0);
		emit(op_equ, 0);
		emit(op_jiz, 12);
		emit(op_jmp, 11);
		emit(op_lod, 0);
		emit(op_jmp, 2);
		for (int c = start; c > 0; c--) begin
			expect_out(7, word_t'(c));
		end
		run_program(exp_data.size());
		compare_outputs();
		finish_test();
	endtask

	task automatic nested_calls();
		begin_test("calls");
		emit(op_cal, 10);
		emit(op_ldc, 'h0a3);
		emit(op_out, 3);
		emit(op_jmp, 3);
		// Outer subroutine
		place(10);
		emit(op_ldc, 'h011);
		emit(op_out, 1);
		emit(op_cal, 20);
		emit(op_ldc, 'h013);
		emit(op_out, 2);
		emit(op_ret, 0);
		// Inner subroutine
		place(20);
		emit(op_ldc, 'h020);
		emit(op_out, 4);
		emit(op_ret, 0);
		expect_out(1, 16'h0011);
		expect_out(4, 16'h0020);
		expect_out(2, 16'h0013);
		expect_out(3, 16'h00a3);
		run_program(exp_data.size());
		compare_outputs();
		finish_test();
	endtask

	task automatic input_port();
		begin_test("input");
		emit(op_inn, 9);
		emit(op_out, 6);
		emit(op_inn, 4);
		emit(op_inv, 0);
		emit(op_out, 14);
		run_program(2);
		if (in_addr.size() != 2) begin
			report_error($sformatf("req_in pulsed %0d times, expected 2", in_addr.size()));
		end else begin
			check_ioaddr("addr_in[0]", in_addr[0], 4'h9);
			check_ioaddr("addr_in[1]", in_addr[1], 4'h4);
			// Output data follows the io_in seen in each inn cycle
			expect_out(6, in_data[0]);
			expect_out(14, ~in_data[1]);
			compare_outputs();
		end
		finish_test();
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		rst = 1'b1;
		instr = '0;
		io_in = '0;
		errors = 0;
		test_errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		since_rst = 0;
		first_out = -1;
		fill_ptr = 0;
		cur_test = "init";
		void'($urandom(32'h1007));
		for (int i = 0; i < 256; i++) begin
			io_table[i] = word_t'($urandom);
		end

		constant_outputs();
		stack_arith();
		memory_roundtrip();
		countdown_loop();
		nested_calls();
		input_port();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/lifo.sv
hdl/alu.sv
hdl/data_ram.sv
hdl/io_port.sv
hdl/instr_dec.sv
hdl/exec_unit.sv
hdl/instr_fetch.sv
hdl/core_top.sv
bench/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module core_tb -Mdir obj_dir -o core_sim

output="$(./obj_dir/core_sim)"
echo "$output"

if grep -qx "SIMULATION PASSED" <<< "$output"; then
	exit 0
fi
exit 1
